// ==== sfifo_ctrl_top.f ====
+incdir+.
sfifo_pkg.sv
sfifo_occupancy.sv
sfifo_flags.sv
sfifo_addr_gen.sv
sfifo_ctrl_top.sv
tb_sfifo_ctrl.sv

// ==== tb_sfifo_ctrl.sv ====
/*
 * testbench for the sync FIFO controller
 * occupancy model plus concurrent checks on every output
 */

`include "sfifo_defines.svh"

module tb_sfifo_ctrl
   import sfifo_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int WAIT_LIMIT = 64;                      // cycles per wait loop
   localparam logic [20:0] RST_EXP = {8'b0011_0000, 13'h0};   // empty, aempty

   logic pos_clk = 1'b0;
   logic aresetn;
   logic we_i;
   logic re_i;
   logic full_o, afull_o, empty_o, aempty_o;
   logic wack_o, dvld_o, overflow_o, underflow_o;
   logic mem_we_o, mem_re_o;
   cnt_t fill_count_o;
   ptr_t mem_waddr_o, mem_raddr_o;

   int   fail_cnt = 0;      // failed checks
   int   tests_passed = 0;
   int   tests_failed = 0;
   logic timed_out = 1'b0;

   always #50 pos_clk = ~pos_clk;   // 100 ns period

   sfifo_ctrl_top i_sfifo_ctrl_top (
      .pos_clk      (pos_clk),
      .aresetn      (aresetn),
      .we_i         (we_i),
      .re_i         (re_i),
      .full_o       (full_o),
      .afull_o      (afull_o),
      .empty_o      (empty_o),
      .aempty_o     (aempty_o),
      .wack_o       (wack_o),
      .dvld_o       (dvld_o),
      .overflow_o   (overflow_o),
      .underflow_o  (underflow_o),
      .mem_we_o     (mem_we_o),
      .mem_re_o     (mem_re_o),
      .fill_count_o (fill_count_o),
      .mem_waddr_o  (mem_waddr_o),
      .mem_raddr_o  (mem_raddr_o)
   );

   // --------------------
   // reference model
   // --------------------
   int   m_count, m_wr_total, m_rd_total;   // words held, accepted ops so far
   logic m_wack, m_dvld, m_ovf, m_unf;
   logic acc_w, acc_r;
   logic [20:0] rst_view;

   assign acc_w = we_i && !full_o;    // acceptance against last-cycle flags
   assign acc_r = re_i && !empty_o;
   assign rst_view = {full_o, afull_o, empty_o, aempty_o, wack_o, dvld_o,
                      overflow_o, underflow_o, fill_count_o, mem_waddr_o, mem_raddr_o};

   always @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         m_count    <= 0;
         m_wr_total <= 0;
         m_rd_total <= 0;
         m_wack     <= 1'b0;
         m_dvld     <= 1'b0;
         m_ovf      <= 1'b0;
         m_unf      <= 1'b0;
      end else begin
         m_count    <= m_count + (acc_w ? 1 : 0) - (acc_r ? 1 : 0);   // both = hold
         m_wr_total <= m_wr_total + (acc_w ? 1 : 0);
         m_rd_total <= m_rd_total + (acc_r ? 1 : 0);
         m_wack     <= acc_w;
         m_dvld     <= acc_r;
         m_ovf      <= we_i && full_o;    // dropped write
         m_unf      <= re_i && empty_o;   // dropped read
      end
   end

   task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                  input logic [31:0] act);
      fail_cnt++;
      $display("CHECK FAILED %s expected 0x%0h actual 0x%0h at %0t", sig, exp, act, $time);
   endtask

   // --------------------
   // output checks
   // --------------------
   a_reset_state : assert property (@(posedge pos_clk) $rose(aresetn) |-> rst_view == RST_EXP)
      else report_mismatch("reset outputs", RST_EXP, $sampled(rst_view));
   a_count : assert property (@(posedge pos_clk) disable iff (!aresetn)
      fill_count_o == cnt_t'(m_count))
      else report_mismatch("fill_count_o", $sampled(m_count), $sampled(fill_count_o));
   a_full : assert property (@(posedge pos_clk) disable iff (!aresetn)
      full_o == (m_count == `SFIFO_DEPTH))
      else report_mismatch("full_o", $sampled(m_count == `SFIFO_DEPTH), $sampled(full_o));
   a_afull : assert property (@(posedge pos_clk) disable iff (!aresetn)
      afull_o == (m_count >= `SFIFO_AFULL_VAL))
      else report_mismatch("afull_o", $sampled(m_count >= `SFIFO_AFULL_VAL), $sampled(afull_o));
   a_empty : assert property (@(posedge pos_clk) disable iff (!aresetn)
      empty_o == (m_count == 0))
      else report_mismatch("empty_o", $sampled(m_count == 0), $sampled(empty_o));
   a_aempty : assert property (@(posedge pos_clk) disable iff (!aresetn)
      aempty_o == (m_count <= `SFIFO_AEMPTY_VAL))
      else report_mismatch("aempty_o", $sampled(m_count <= `SFIFO_AEMPTY_VAL),
                           $sampled(aempty_o));
   a_wack : assert property (@(posedge pos_clk) disable iff (!aresetn) wack_o == m_wack)
      else report_mismatch("wack_o", $sampled(m_wack), $sampled(wack_o));
   a_dvld : assert property (@(posedge pos_clk) disable iff (!aresetn) dvld_o == m_dvld)
      else report_mismatch("dvld_o", $sampled(m_dvld), $sampled(dvld_o));
   a_ovf : assert property (@(posedge pos_clk) disable iff (!aresetn) overflow_o == m_ovf)
      else report_mismatch("overflow_o", $sampled(m_ovf), $sampled(overflow_o));
   a_unf : assert property (@(posedge pos_clk) disable iff (!aresetn) underflow_o == m_unf)
      else report_mismatch("underflow_o", $sampled(m_unf), $sampled(underflow_o));
   a_mem_we : assert property (@(posedge pos_clk) disable iff (!aresetn) mem_we_o == acc_w)
      else report_mismatch("mem_we_o", $sampled(acc_w), $sampled(mem_we_o));
   a_mem_re : assert property (@(posedge pos_clk) disable iff (!aresetn) mem_re_o == acc_r)
      else report_mismatch("mem_re_o", $sampled(acc_r), $sampled(mem_re_o));
   // addresses are accepted totals mod depth
   a_waddr : assert property (@(posedge pos_clk) disable iff (!aresetn)
      mem_waddr_o == ptr_t'(m_wr_total))
      else report_mismatch("mem_waddr_o", ptr_t'($sampled(m_wr_total)), $sampled(mem_waddr_o));
   a_raddr : assert property (@(posedge pos_clk) disable iff (!aresetn)
      mem_raddr_o == ptr_t'(m_rd_total))
      else report_mismatch("mem_raddr_o", ptr_t'($sampled(m_rd_total)), $sampled(mem_raddr_o));

   // --------------------
   // stimulus helpers
   // --------------------
   task automatic drive(input logic w, input logic r);
      @(posedge pos_clk);
      we_i <= w;
      re_i <= r;
   endtask

   // poll at negedge where flags are settled
   task automatic wait_status(input bit for_full);
      int n;
      n = 0;
      @(negedge pos_clk);
      while ((for_full ? full_o : empty_o) !== 1'b1 && !timed_out) begin
         if (n >= WAIT_LIMIT) begin
            timed_out = 1'b1;
            $display("timeout waiting for %s", for_full ? "full_o" : "empty_o");
         end else begin
            @(negedge pos_clk);
            n++;
         end
      end
   endtask

   task automatic fill_to_full();
      int i;
      for (i = 0; i < `SFIFO_DEPTH; i++)
         drive(1'b1, 1'b0);
      drive(1'b0, 1'b0);
      wait_status(1'b1);
      drive(1'b1, 1'b0);   // single write into a full FIFO
      drive(1'b0, 1'b0);
   endtask

   task automatic drain_to_empty();
      int i;
      for (i = 0; i < `SFIFO_DEPTH; i++)
         drive(1'b0, 1'b1);
      drive(1'b0, 1'b0);
      wait_status(1'b0);
      drive(1'b0, 1'b1);   // read from empty
      drive(1'b0, 1'b0);
   endtask

   task automatic handshake_mix();
      int i;
      for (i = 0; i < 4; i++) begin
         drive(1'b1, 1'b0);
         drive(1'b1, 1'b1);   // simultaneous
         drive(1'b0, 1'b1);
         drive(1'b1, 1'b0);
         drive(1'b0, 1'b0);
         drive(1'b0, 1'b1);
      end
      drive(1'b0, 1'b0);
      wait_status(1'b0);
   endtask

   task automatic wrap_addresses();
      int i, k;
      for (i = 0; i < 8; i++) begin   // 24 of each, past one lap
         for (k = 0; k < 3; k++)
            drive(1'b1, 1'b0);
         for (k = 0; k < 3; k++)
            drive(1'b0, 1'b1);
      end
      drive(1'b0, 1'b0);
      wait_status(1'b0);
   endtask

   task automatic random_traffic();
      int i, w_pct;
      for (i = 0; i < 500; i++) begin
         w_pct = ((i % 100) < 50) ? 70 : 30;   // write-heavy then read-heavy phases
         drive(($urandom % 100) < w_pct, ($urandom % 100) < (100 - w_pct));
      end
      drive(1'b0, 1'b0);
   endtask

   task automatic finish_test(input string name, input int fails_before);
      drive(1'b0, 1'b0);
      drive(1'b0, 1'b0);
      @(negedge pos_clk);
      if (fail_cnt == fails_before && !timed_out) begin
         tests_passed++;
         $display("test %-16s ok", name);
      end else begin
         tests_failed++;
         $display("test %-16s FAILED (%0d checks)", name, fail_cnt - fails_before);
      end
   endtask

   // --------------------
   // main sequence
   // --------------------
   initial begin
      int fails_before;
      aresetn = 1'b0;
      we_i    = 1'b0;
      re_i    = 1'b0;
      void'($urandom(32'h0d880303));
      fails_before = fail_cnt;
      repeat (3) @(posedge pos_clk);
      aresetn <= 1'b1;
      finish_test("reset_state", fails_before);
      fails_before = fail_cnt;
      fill_to_full();
      finish_test("fill_to_full", fails_before);
      if (!timed_out) begin
         fails_before = fail_cnt;
         drain_to_empty();
         finish_test("drain_to_empty", fails_before);
      end
      if (!timed_out) begin
         fails_before = fail_cnt;
         handshake_mix();
         finish_test("handshake", fails_before);
      end
      if (!timed_out) begin
         fails_before = fail_cnt;
         wrap_addresses();
         finish_test("address_wrap", fails_before);
      end
      if (!timed_out) begin
         fails_before = fail_cnt;
         random_traffic();
         finish_test("random_traffic", fails_before);
      end
      $display("tests ok %0d, tests failed %0d, check failures %0d",
               tests_passed, tests_failed, fail_cnt);
      if (tests_failed == 0 && fail_cnt == 0 && !timed_out)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

// ==== sfifo_ctrl_top.sv ====
/*
 * sync FIFO controller top
 * occupancy, flags and address generation for an external memory
 */

module sfifo_ctrl_top
   import sfifo_pkg::*;
(
   input  logic pos_clk,
   input  logic aresetn,
   input  logic we_i,           // write request
   input  logic re_i,           // read request
   output logic full_o,
   output logic afull_o,
   output logic empty_o,
   output logic aempty_o,
   output logic wack_o,
   output logic dvld_o,
   output logic overflow_o,
   output logic underflow_o,
   output logic mem_we_o,       // memory write enable
   output logic mem_re_o,       // memory read enable
   output cnt_t fill_count_o,
   output ptr_t mem_waddr_o,
   output ptr_t mem_raddr_o
);

   // --------------------
   // internal nets
   // --------------------
   logic     wr_ok;
   logic     rd_ok;
   fifo_op_e op;
   cnt_t     count;

   // request qualification and fill counter
   sfifo_occupancy i_sfifo_occupancy (
      .pos_clk (pos_clk),
      .aresetn (aresetn),
      .we_i    (we_i),
      .re_i    (re_i),
      .full_i  (full_o),    // flags loop back for gating
      .empty_i (empty_o),
      .wr_ok_o (wr_ok),
      .rd_ok_o (rd_ok),
      .op_o    (op),
      .count_o (count)
   );

   // status, handshake and error flags
   sfifo_flags i_sfifo_flags (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .we_i        (we_i),
      .re_i        (re_i),
      .wr_ok_i     (wr_ok),
      .rd_ok_i     (rd_ok),
      .op_i        (op),
      .count_i     (count),
      .full_o      (full_o),
      .afull_o     (afull_o),
      .empty_o     (empty_o),
      .aempty_o    (aempty_o),
      .wack_o      (wack_o),
      .dvld_o      (dvld_o),
      .overflow_o  (overflow_o),
      .underflow_o (underflow_o)
   );

   // memory pointers
   sfifo_addr_gen i_sfifo_addr_gen (
      .pos_clk (pos_clk),
      .aresetn (aresetn),
      .wr_ok_i (wr_ok),
      .rd_ok_i (rd_ok),
      .waddr_o (mem_waddr_o),
      .raddr_o (mem_raddr_o)
   );

   // memory enables are the same-cycle accepted requests
   assign mem_we_o     = wr_ok;
   assign mem_re_o     = rd_ok;
   assign fill_count_o = count;

endmodule

// ==== sfifo_addr_gen.sv ====
/*
 * sync FIFO address generator
 * write and read pointers for the external memory
 */

`include "sfifo_defines.svh"

module sfifo_addr_gen
   import sfifo_pkg::*;
(
   input  logic pos_clk,
   input  logic aresetn,
   input  logic wr_ok_i,   // accepted write
   input  logic rd_ok_i,   // accepted read
   output ptr_t waddr_o,
   output ptr_t raddr_o
);

   localparam ptr_t LAST_ADDR = ptr_t'(`SFIFO_DEPTH - 1);

   ptr_t waddr_r;
   ptr_t raddr_r;

   // --------------------
   // write pointer
   // --------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         waddr_r <= '0;
      end else if (wr_ok_i) begin
         if (waddr_r == LAST_ADDR)
            waddr_r <= '0;   // wrap
         else
            waddr_r <= waddr_r + ptr_t'(1);
      end
   end

   // --------------------
   // read pointer
   // --------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         raddr_r <= '0;
      end else if (rd_ok_i) begin
         if (raddr_r == LAST_ADDR)
            raddr_r <= '0;
         else
            raddr_r <= raddr_r + ptr_t'(1);
      end
   end

   assign waddr_o = waddr_r;
   assign raddr_o = raddr_r;

endmodule

// ==== sfifo_flags.sv ====
/*
 * sync FIFO status flags
 * registered full/afull/empty/aempty from the next count,
 * wack/dvld handshake pulses and overflow/underflow errors
 */

`include "sfifo_defines.svh"

module sfifo_flags
   import sfifo_pkg::*;
(
   input  logic     pos_clk,
   input  logic     aresetn,
   input  logic     we_i,         // raw write request
   input  logic     re_i,         // raw read request
   input  logic     wr_ok_i,      // accepted write
   input  logic     rd_ok_i,      // accepted read
   input  fifo_op_e op_i,
   input  cnt_t     count_i,      // current fill count
   output logic     full_o,
   output logic     afull_o,
   output logic     empty_o,
   output logic     aempty_o,
   output logic     wack_o,
   output logic     dvld_o,
   output logic     overflow_o,
   output logic     underflow_o
);

   cnt_t count_nxt;   // count after this edge
   logic flag_upd;    // count actually moves

   // --------------------
   // next count
   // --------------------
   // mirrors the counter so flags land on the same edge as the count
   always_comb begin
      case (op_i)
         OP_PUSH: count_nxt = count_i + cnt_t'(1);
         OP_POP:  count_nxt = count_i - cnt_t'(1);
         default: count_nxt = count_i;
      endcase
   end

   assign flag_upd = (op_i == OP_PUSH) || (op_i == OP_POP);

   // --------------------
   // status flags
   // --------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         full_o   <= 1'b0;
         afull_o  <= 1'b0;
         empty_o  <= 1'b1;   // starts empty
         aempty_o <= 1'b1;
      end else if (flag_upd) begin
         full_o   <= (count_nxt == cnt_t'(`SFIFO_DEPTH));
         afull_o  <= (count_nxt >= cnt_t'(`SFIFO_AFULL_VAL));
         empty_o  <= (count_nxt == '0);
         aempty_o <= (count_nxt <= cnt_t'(`SFIFO_AEMPTY_VAL));
      end
   end

   // --------------------
   // handshake pulses
   // --------------------
   // one cycle after each accepted op, dvld lines up with the
   // memory's registered read data
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wack_o <= 1'b0;
         dvld_o <= 1'b0;
      end else begin
         wack_o <= wr_ok_i;
         dvld_o <= rd_ok_i;
      end
   end

   // --------------------
   // error pulses
   // --------------------
   // raw requests against the flags seen this cycle
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         overflow_o  <= 1'b0;
         underflow_o <= 1'b0;
      end else begin
         overflow_o  <= we_i & full_o;    // write dropped
         underflow_o <= re_i & empty_o;   // read dropped
      end
   end

   // --------------------
   // checks
   // --------------------
   a_not_full_empty : assert property (
      @(posedge pos_clk) disable iff (!aresetn)
      !(full_o && empty_o)
   ) else $error("full and empty both set");

   // threshold ordering holds across every update
   a_full_afull : assert property (
      @(posedge pos_clk) disable iff (!aresetn)
      full_o |-> afull_o
   ) else $error("full without afull");

endmodule

// ==== sfifo_occupancy.sv ====
/*
 * sync FIFO occupancy
 * qualifies write/read requests against full and empty,
 * encodes the cycle's opcode and keeps the fill counter
 */

`include "sfifo_defines.svh"

module sfifo_occupancy
   import sfifo_pkg::*;
(
   input  logic     pos_clk,
   input  logic     aresetn,
   input  logic     we_i,      // raw write request
   input  logic     re_i,      // raw read request
   input  logic     full_i,    // registered full from flags
   input  logic     empty_i,   // registered empty from flags
   output logic     wr_ok_o,   // accepted write
   output logic     rd_ok_o,   // accepted read
   output fifo_op_e op_o,
   output cnt_t     count_o
);

   logic     wr_ok;
   logic     rd_ok;
   fifo_op_e op;
   cnt_t     count_r;

   // --------------------
   // request qualification
   // --------------------
   // the only place full/empty gate a request
   assign wr_ok = we_i & ~full_i;
   assign rd_ok = re_i & ~empty_i;

   // --------------------
   // opcode decode
   // --------------------
   always_comb begin
      case ({wr_ok, rd_ok})
         2'b10:   op = OP_PUSH;
         2'b01:   op = OP_POP;
         2'b11:   op = OP_BOTH;   // simultaneous, no net change
         default: op = OP_IDLE;
      endcase
   end

   // --------------------
   // fill counter
   // --------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         count_r <= '0;
      end else begin
         case (op)
            OP_PUSH: count_r <= count_r + cnt_t'(1);
            OP_POP:  count_r <= count_r - cnt_t'(1);
            default: count_r <= count_r;   // idle or both
         endcase
      end
   end

   assign wr_ok_o = wr_ok;
   assign rd_ok_o = rd_ok;
   assign op_o    = op;
   assign count_o = count_r;

   // --------------------
   // checks
   // --------------------
   // counter bounded by depth, relies on full from flags blocking pushes
   a_count_max : assert property (
      @(posedge pos_clk) disable iff (!aresetn)
      count_r <= cnt_t'(`SFIFO_DEPTH)
   ) else $error("count 0x%0h above depth", count_r);

   // empty comes back registered from flags; no pop may slip through it
   a_no_pop_empty : assert property (
      @(posedge pos_clk) disable iff (!aresetn)
      empty_i |-> (op != OP_POP)
   ) else $error("pop decoded while empty");

   // counter must be zero whenever flags report empty
   a_empty_zero : assert property (
      @(posedge pos_clk) disable iff (!aresetn)
      empty_i |-> (count_r == '0)
   ) else $error("empty with count 0x%0h", count_r);

endmodule

// ==== sfifo_pkg.sv ====
/*
 * sync FIFO controller types
 * counter opcode plus pointer and count widths
 */

`include "sfifo_defines.svh"

package sfifo_pkg;

   // --------------------
   // counter operation
   // --------------------
   // one code per cycle, decoded from the qualified enables
   typedef enum logic [1:0] {
      OP_IDLE = 2'b00,   // nothing accepted
      OP_PUSH = 2'b01,   // write only
      OP_POP  = 2'b10,   // read only
      OP_BOTH = 2'b11    // write and read together, count holds
   } fifo_op_e;

   // --------------------
   // datapath widths
   // --------------------
   typedef logic [`SFIFO_AW-1:0] ptr_t;   // memory address
   typedef logic [`SFIFO_CW-1:0] cnt_t;   // words held

endpackage

// ==== sfifo_defines.svh ====
/*
 * sync FIFO controller size and thresholds
 * one fixed build, depth must stay a power of two
 */

`ifndef SFIFO_DEFINES_SVH
`define SFIFO_DEFINES_SVH

// --------------------
// memory geometry
// --------------------
`define SFIFO_DEPTH      16                // words in the external memory
`define SFIFO_AW         4                 // log2 of depth
`define SFIFO_CW         (`SFIFO_AW + 1)   // count holds 0..depth inclusive

// --------------------
// static flag thresholds
// --------------------
`define SFIFO_AFULL_VAL  12    // afull when count at or above
`define SFIFO_AEMPTY_VAL 4     // aempty when count at or below

`endif
